// ==== Makefile ====
# Verilator build and run for the I2S loopback testbench

SRC := $(shell grep -v '^+' filelist.f)

obj_dir/Vboard_tb: filelist.f $(SRC)
	verilator --binary --assert -Wno-fatal -f filelist.f --top-module board_tb

run: obj_dir/Vboard_tb
	./obj_dir/Vboard_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== filelist.f ====
logic/board_pkg.sv
logic/i2s_timing_if.sv
logic/i2s_clock_divider.sv
logic/i2s_mic_receiver.sv
logic/i2s_audio_transmitter.sv
logic/audio_mode_fsm.sv
logic/board_specific_top.sv
tb/board_asserts.sv
tb/board_tb.sv

// ==== logic/audio_mode_fsm.sv ====
// Key-driven speaker mode FSM with sound selection and mode LEDs
module audio_mode_fsm (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [board_pkg::w_key         - 1:0] key,
    input  logic [board_pkg::w_mic         - 1:0] sample,
    input  logic                                  sample_valid,
    input  logic [board_pkg::w_frame_count - 1:0] frame_count,
    output board_pkg::audio_mode_t                mode,
    output logic [board_pkg::w_led         - 1:0] led,
    output logic [board_pkg::w_sound       - 1:0] sound
);

    logic [board_pkg::w_key - 1:0] key_meta;
    logic [board_pkg::w_key - 1:0] key_sync;
    logic [board_pkg::w_key - 1:0] key_prev;
    logic [board_pkg::w_key - 1:0] key_rise;

    //----------------------------------------------------------------------
    // Key synchronizer and press detector

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    assign key_rise = key_sync & ~key_prev;

    //----------------------------------------------------------------------
    // Mode and sound

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mode <= board_pkg::mode_pass;
        else if (key_rise[0])              // Lowest key wins
            mode <= board_pkg::mode_mute;
        else if (key_rise[1])
            mode <= board_pkg::mode_tone;
        else if (key_rise[2])
            mode <= board_pkg::mode_pass;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sound <= '0;
        end else if (sample_valid) begin
            case (mode)
                board_pkg::mode_pass: sound <= sample[board_pkg::w_mic - 1 -: board_pkg::w_sound];
                board_pkg::mode_tone: sound <= frame_count[board_pkg::tone_bit]
                                                   ? -board_pkg::tone_amplitude
                                                   :  board_pkg::tone_amplitude;
                default:              sound <= '0;  // Mute
            endcase
        end
    end

    assign led = {sound[board_pkg::w_sound - 1],   // Negative half of the wave
                  mode == board_pkg::mode_tone,
                  mode == board_pkg::mode_mute,
                  mode == board_pkg::mode_pass};

endmodule

// ==== logic/board_pkg.sv ====
// Board constants, I2S framing constants and the speaker mode type
package board_pkg;

    //----------------------------------------------------------------------
    // Board

    localparam int clk_mhz = 50;             // System clock
    localparam int w_key   = 4;
    localparam int w_led   = 4;

    //----------------------------------------------------------------------
    // I2S framing

    localparam int bclk_div          = 8;    // System clocks per bit clock
    localparam int w_phase           = $clog2(bclk_div);
    localparam int slots_per_channel = 32;
    localparam int w_slot            = $clog2(2 * slots_per_channel);
    localparam int w_frame_count     = 16;

    localparam logic [w_phase - 1:0] phase_rise = w_phase'(bclk_div / 2 - 1);
    localparam logic [w_phase - 1:0] phase_fall = w_phase'(bclk_div - 1);

    localparam logic [w_slot - 1:0] slot_one   = w_slot'(1);  // MSB slot of a channel
    localparam logic [w_slot - 1:0] slot_right = w_slot'(slots_per_channel);
    localparam logic [w_slot - 1:0] slot_last  = w_slot'(2 * slots_per_channel - 1);

    //----------------------------------------------------------------------
    // Audio

    localparam int w_mic   = 24;
    localparam int w_sound = 16;

    localparam logic [w_slot - 1:0] mic_last_slot   = w_slot'(w_mic);
    localparam logic [w_slot - 1:0] sound_last_slot = w_slot'(w_sound);

    localparam logic [w_sound - 1:0] tone_amplitude   = 16'h2000;
    localparam int                   tone_half_frames = 32;
    localparam int                   tone_bit         = $clog2(tone_half_frames);

    typedef enum logic [1:0] {
        mode_pass = 2'd0,
        mode_mute = 2'd1,
        mode_tone = 2'd2
    } audio_mode_t;

endpackage

// ==== logic/board_specific_top.sv ====
// Board top for the I2S microphone to DAC loopback with mode keys and LEDs
module board_specific_top (
    input                             CLK,
    input                             arst_n,

    input  [board_pkg::w_key - 1:0]   key,      // Active low
    output [board_pkg::w_led - 1:0]   led,      // Active low

    output                            mic_sck,
    output                            mic_ws,
    output                            mic_lr,
    output                            mic_vdd,
    output                            mic_gnd,
    input                             mic_sd,

    output                            aud_mclk,
    output                            aud_bclk,
    output                            aud_lrclk,
    output                            aud_sdata
);

    //----------------------------------------------------------------------

    wire                            clk     = CLK;
    wire [board_pkg::w_key - 1:0]   top_key = ~ key;
    wire [board_pkg::w_led - 1:0]   top_led;

    wire [board_pkg::w_mic   - 1:0] mic;
    wire                            mic_valid;
    wire [board_pkg::w_sound - 1:0] sound;

    i2s_timing_if tim ();

    //----------------------------------------------------------------------

    i2s_clock_divider i_divider (
        .clk     ( clk      ),
        .arst_n  ( arst_n   ),
        .mclk    ( aud_mclk ),
        .tim     ( tim      )
    );

    i2s_mic_receiver i_microphone (
        .clk          ( clk       ),
        .arst_n       ( arst_n    ),
        .tim          ( tim       ),
        .sd           ( mic_sd    ),
        .sample       ( mic       ),
        .sample_valid ( mic_valid )
    );

    audio_mode_fsm i_mode (
        .clk          ( clk             ),
        .arst_n       ( arst_n          ),
        .key          ( top_key         ),
        .sample       ( mic             ),
        .sample_valid ( mic_valid       ),
        .frame_count  ( tim.frame_count ),
        .mode         (                 ),  // Shown on the LEDs
        .led          ( top_led         ),
        .sound        ( sound           )
    );

    i2s_audio_transmitter o_audio (
        .clk     ( clk       ),
        .arst_n  ( arst_n    ),
        .tim     ( tim       ),
        .sound   ( sound     ),
        .sdata   ( aud_sdata )
    );

    //----------------------------------------------------------------------

    assign led       = ~ top_led;

    assign mic_sck   = tim.bclk;
    assign mic_ws    = tim.ws;
    assign aud_bclk  = tim.bclk;
    assign aud_lrclk = tim.ws;

    assign mic_lr    = 1'b0;  // Left channel
    assign mic_gnd   = 1'b0;
    assign mic_vdd   = 1'b1;

endmodule

// ==== logic/i2s_audio_transmitter.sv ====
// I2S DAC transmitter sending one 16-bit sound on both channels
module i2s_audio_transmitter (
    input  logic                            clk,
    input  logic                            arst_n,
    i2s_timing_if.sink                      tim,
    input  logic [board_pkg::w_sound - 1:0] sound,
    output logic                            sdata
);

    logic [board_pkg::w_sound - 1:0] hold;   // Word for the current frame
    logic [board_pkg::w_sound - 1:0] shift;
    logic [board_pkg::w_slot  - 1:0] next_slot;
    logic [board_pkg::w_slot  - 1:0] pos;    // Slot within a channel

    assign next_slot = tim.slot + 1;
    assign pos       = {1'b0, next_slot[board_pkg::w_slot - 2:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            hold <= '0;
        else if (tim.frame_start)
            hold <= sound;
    end

    // Each bit is set up on the fall before its slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift <= '0;
            sdata <= 1'b0;
        end else if (tim.bclk_fall) begin
            if (pos == '0) begin
                // Slot 0 takes the new word, slot 32 repeats it
                shift <= tim.frame_start ? sound : hold;
                sdata <= 1'b0;
            end else if (pos <= board_pkg::sound_last_slot) begin
                sdata <= shift[board_pkg::w_sound - 1];  // MSB first
                shift <= {shift[board_pkg::w_sound - 2:0], 1'b0};
            end else begin
                sdata <= 1'b0;                            // Padding slots
            end
        end
    end

endmodule

// ==== logic/i2s_clock_divider.sv ====
// I2S timing generator for mclk, bclk, word select, strobes and frames
module i2s_clock_divider (
    input  logic         clk,
    input  logic         arst_n,
    output logic         mclk,
    i2s_timing_if.source tim
);

    logic [board_pkg::w_phase       - 1:0] phase;
    logic                                  bclk;
    logic [board_pkg::w_slot        - 1:0] slot;
    logic [board_pkg::w_frame_count - 1:0] frame_count;

    logic bclk_rise;
    logic bclk_fall;
    logic frame_start;

    //----------------------------------------------------------------------
    // Bit clock

    assign bclk_rise = (phase == board_pkg::phase_rise);
    assign bclk_fall = (phase == board_pkg::phase_fall);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
            bclk  <= 1'b0;
        end else begin
            phase <= phase + 1;
            if (bclk_rise)
                bclk <= 1'b1;
            else if (bclk_fall)
                bclk <= 1'b0;
        end
    end

    assign mclk = phase[0];  // clk / 2

    //----------------------------------------------------------------------
    // Slot and frame position

    assign frame_start = bclk_fall && (slot == board_pkg::slot_last);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot        <= '0;
            frame_count <= '0;
        end else if (bclk_fall) begin
            slot <= slot + 1;  // Wraps 63 -> 0
            if (frame_start)
                frame_count <= frame_count + 1;
        end
    end

    assign tim.bclk        = bclk;
    assign tim.ws          = (slot >= board_pkg::slot_right);  // Moves with the slot on the fall
    assign tim.bclk_rise   = bclk_rise;
    assign tim.bclk_fall   = bclk_fall;
    assign tim.slot        = slot;
    assign tim.frame_start = frame_start;
    assign tim.frame_count = frame_count;

endmodule

// ==== logic/i2s_mic_receiver.sv ====
// I2S microphone receiver for the 24-bit left-channel sample
module i2s_mic_receiver (
    input  logic                            clk,
    input  logic                            arst_n,
    i2s_timing_if.sink                      tim,
    input  logic                            sd,
    output logic [board_pkg::w_mic - 1:0]   sample,
    output logic                            sample_valid
);

    logic [1:0]                     sd_sync;
    logic [board_pkg::w_mic - 1:0]  shift;
    logic                           capture;
    logic                           last_bit;

    // Left data bits sit in slots 1 to 24
    assign capture  = tim.bclk_rise
                   && (tim.slot >= board_pkg::slot_one)
                   && (tim.slot <= board_pkg::mic_last_slot);
    assign last_bit = capture && (tim.slot == board_pkg::mic_last_slot);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            sd_sync <= '0;
        else
            sd_sync <= {sd_sync[0], sd};  // Two-flop synchronizer
    end

    always_ff @(posedge clk) begin
        if (capture)
            shift <= {shift[board_pkg::w_mic - 2:0], sd_sync[1]};
        if (last_bit)
            sample <= {shift[board_pkg::w_mic - 2:0], sd_sync[1]};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= last_bit;  // One pulse per frame
    end

endmodule

// ==== logic/i2s_timing_if.sv ====
// Shared I2S bit clock, word select, strobes and frame position
interface i2s_timing_if;

    logic                                  bclk;
    logic                                  ws;           // Low for left channel
    logic                                  bclk_rise;    // Cycle before bclk rises
    logic                                  bclk_fall;    // Cycle before bclk falls
    logic [board_pkg::w_slot        - 1:0] slot;
    logic                                  frame_start;  // With the fall that begins slot 0
    logic [board_pkg::w_frame_count - 1:0] frame_count;

    modport source (
        output bclk, ws,
        output bclk_rise, bclk_fall,
        output slot, frame_start, frame_count
    );

    modport sink (
        input bclk, ws,
        input bclk_rise, bclk_fall,
        input slot, frame_start, frame_count
    );

endinterface

// ==== tb/audio_input.mem ====
// Columns: key code (active high, bit 0 mute, bit 1 tone, bit 2 pass) _ 24-bit mic sample
// _ expected 16-bit DAC word; tone lines hold the positive tone level
0_123456_1234
0_89abcd_89ab
0_fedcba_fedc
0_0000ff_0000
1_7fffff_0000
0_555555_0000
0_aaaaaa_0000
2_112233_2000
0_445566_2000
0_778899_2000
4_c0ffee_c0ff
0_13579b_1357
5_2468ac_0000
0_800000_0000
4_800000_8000
0_7fff00_7fff
0_0f1e2d_0f1e
0_a5a5a5_a5a5

// ==== tb/board_asserts.sv ====
// Concurrent checks on I2S timing strobes, word select and the speaker mode, with the bind
module board_asserts (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   bclk,
    input logic                   ws,
    input logic                   bclk_rise,
    input logic                   bclk_fall,
    input board_pkg::audio_mode_t mode
);

    // Word select moves only on the edge after a fall strobe
    ws_at_fall: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(ws) |-> $past(bclk_fall))
        else $error("word select changed away from a bclk fall");

    // Each strobe leads its bclk edge by one cycle
    rise_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        bclk_rise |=> $rose(bclk))
        else $error("bclk did not rise after its rise strobe");

    fall_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        bclk_fall |=> $fell(bclk))
        else $error("bclk did not fall after its fall strobe");

    mode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        mode == board_pkg::mode_pass || mode == board_pkg::mode_mute
            || mode == board_pkg::mode_tone)
        else $error("mode holds a value outside the mode enum");

endmodule

bind board_specific_top board_asserts board_checks (
    .clk(clk), .arst_n(arst_n), .bclk(tim.bclk), .ws(tim.ws),
    .bclk_rise(tim.bclk_rise), .bclk_fall(tim.bclk_fall), .mode(i_mode.mode)
);

// ==== tb/board_tb.sv ====
// Testbench for the board top: clock, reset, I2S microphone model, DAC decoder, checks, timeout
module board_tb;

    localparam int n_vec      = 18;
    localparam int frame_clks = 2 * board_pkg::slots_per_channel * board_pkg::bclk_div;
    localparam int limit      = (n_vec + 4) * frame_clks;
    localparam int n_window   = n_vec / board_pkg::tone_half_frames + 1;
    localparam int right_msb  = board_pkg::slots_per_channel + 1;

    logic                              CLK;
    logic                              arst_n;
    logic [board_pkg::w_key   - 1:0]   key;
    logic                              mic_sd;
    wire  [board_pkg::w_led   - 1:0]   led;
    wire                               mic_sck;
    wire                               mic_ws;
    wire                               mic_lr;
    wire                               mic_vdd;
    wire                               mic_gnd;
    wire                               aud_mclk;
    wire                               aud_bclk;
    wire                               aud_lrclk;
    wire                               aud_sdata;

    logic [43:0]                       vectors    [0:n_vec - 1];  // Key, mic sample, DAC word
    board_pkg::audio_mode_t            vec_mode   [0:n_vec - 1];
    logic                              tone_seen  [0:n_window - 1];
    logic [board_pkg::w_sound - 1:0]   tone_level [0:n_window - 1];
    board_pkg::audio_mode_t            model_mode = board_pkg::mode_pass;

    int   clk_count    = 0;
    int   last_rise    = -1;
    int   last_ws_fall = -1;
    int   frame        = 0;     // Frame 0 begins at reset release
    int   slot         = 0;
    logic done         = 1'b0;
    logic bclk_q       = 1'b0;
    logic ws_q         = 1'b0;
    logic mclk_q       = 1'b0;
    logic [board_pkg::w_sound - 1:0] left  = '0;
    logic [board_pkg::w_sound - 1:0] right = '0;

    board_specific_top dut0 (
        .CLK       ( CLK       ),
        .arst_n    ( arst_n    ),
        .key       ( key       ),
        .led       ( led       ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .mic_vdd   ( mic_vdd   ),
        .mic_gnd   ( mic_gnd   ),
        .mic_sd    ( mic_sd    ),
        .aud_mclk  ( aud_mclk  ),
        .aud_bclk  ( aud_bclk  ),
        .aud_lrclk ( aud_lrclk ),
        .aud_sdata ( aud_sdata )
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    //----------------------------------------------------------------------
    // Reference model and checks

    function automatic logic [2:0] led_pins(input board_pkg::audio_mode_t m);
        case (m)
            board_pkg::mode_mute: return 3'b101;
            board_pkg::mode_tone: return 3'b011;
            default:              return 3'b110;   // Pass
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic start_frame(input int f);
        logic [board_pkg::w_key - 1:0] code;
        code = vectors[f][43:40];
        key <= ~code;                                   // Active low at the pins
        if (code[0])
            model_mode = board_pkg::mode_mute;          // Lowest key wins
        else if (code[1])
            model_mode = board_pkg::mode_tone;
        else if (code[2])
            model_mode = board_pkg::mode_pass;
        vec_mode[f] = model_mode;
    endtask

    task automatic check_words(input int n);
        logic [board_pkg::w_sound - 1:0] expected;
        logic [board_pkg::w_sound - 1:0] low;
        int                              window;
        string                           name;
        expected = vectors[n][15:0];
        low      = -board_pkg::tone_amplitude;
        window   = n / board_pkg::tone_half_frames;
        name     = (vec_mode[n] == board_pkg::mode_mute) ? "mute" : "passthrough";
        assert (right == left)
            else report_mismatch($sformatf("right word, vector %0d", n), left, right);
        if (vec_mode[n] == board_pkg::mode_tone) begin
            assert (left == board_pkg::tone_amplitude || left == low)
                else report_mismatch($sformatf("tone level, vector %0d", n),
                                     board_pkg::tone_amplitude, left);
            if (tone_seen[window]) begin
                assert (left == tone_level[window])
                    else report_mismatch($sformatf("tone sign, vector %0d", n),
                                         tone_level[window], left);
            end
            tone_seen[window]  = 1'b1;
            tone_level[window] = left;
        end else begin
            assert (left == expected)
                else report_mismatch($sformatf("%s, vector %0d", name, n), expected, left);
        end
    endtask

    // Word select just went low, so a new frame begins
    task automatic finish_frame();
        assert (slot == 2 * board_pkg::slots_per_channel - 1)
            else report_mismatch("slots per frame", 63, slot);
        if (last_ws_fall >= 0) begin
            assert (clk_count - last_ws_fall == frame_clks)
                else report_mismatch("lrclk period", frame_clks, clk_count - last_ws_fall);
        end
        last_ws_fall = clk_count;
        if (frame > 0)
            check_words(frame - 1);                     // One frame of latency
        frame = frame + 1;
        slot  = 0;
        if (frame < n_vec)
            start_frame(frame);
        else if (frame > n_vec)
            done = 1'b1;
    endtask

    // Microphone side, one bit per slot after each bclk fall
    task automatic next_slot();
        logic [board_pkg::w_mic - 1:0] sample;
        if (ws_q && !aud_lrclk) begin
            finish_frame();
        end else begin
            slot = slot + 1;
            if (!ws_q && aud_lrclk) begin
                assert (slot == board_pkg::slots_per_channel)
                    else report_mismatch("left slots", board_pkg::slots_per_channel, slot);
                key <= '1;                              // Release all keys
                if (frame < n_vec) begin
                    assert (led[2:0] == led_pins(vec_mode[frame]))
                        else report_mismatch($sformatf("mode led, frame %0d", frame),
                                             led_pins(vec_mode[frame]), led[2:0]);
                    // Sign LED lit for a negative sound
                    if (vec_mode[frame] != board_pkg::mode_tone) begin
                        assert (led[3] == !vectors[frame][15])
                            else report_mismatch($sformatf("sign led, frame %0d", frame),
                                                 !vectors[frame][15], led[3]);
                    end
                end
            end
        end
        sample = (frame < n_vec) ? vectors[frame][39:16] : '0;
        if (slot >= 1 && slot <= board_pkg::w_mic)
            mic_sd <= sample[board_pkg::w_mic - slot];  // MSB in slot 1
        else
            mic_sd <= 1'b0;
    endtask

    // DAC side, sampled after each bclk rise
    task automatic sample_bit();
        if (last_rise >= 0) begin
            assert (clk_count - last_rise == board_pkg::bclk_div)
                else report_mismatch("bclk period", board_pkg::bclk_div, clk_count - last_rise);
        end
        last_rise = clk_count;
        if (frame == 0) begin
            assert (aud_sdata == 1'b0)
                else report_mismatch("sdata before first frame", 0, aud_sdata);
        end
        if (slot >= 1 && slot <= board_pkg::w_sound)
            left = {left[board_pkg::w_sound - 2:0], aud_sdata};
        else if (slot >= right_msb && slot < right_msb + board_pkg::w_sound)
            right = {right[board_pkg::w_sound - 2:0], aud_sdata};
    endtask

    // Microphone clocks, tie-offs and mclk at clk / 2
    task automatic compare_pins();
        assert (mic_sck == aud_bclk && mic_ws == aud_lrclk)
            else report_mismatch("mic clocks", {aud_bclk, aud_lrclk}, {mic_sck, mic_ws});
        assert ({mic_lr, mic_vdd, mic_gnd} == 3'b010)
            else report_mismatch("mic tie-offs", 3'b010, {mic_lr, mic_vdd, mic_gnd});
        if (clk_count > 1) begin
            assert (aud_mclk != mclk_q)
                else report_mismatch("mclk toggle", !mclk_q, aud_mclk);
        end
        mclk_q = aud_mclk;
    endtask

    always @(posedge CLK) begin
        if (arst_n) begin
            clk_count = clk_count + 1;
            compare_pins();
            if (!bclk_q && aud_bclk)
                sample_bit();
            if (bclk_q && !aud_bclk)
                next_slot();
            bclk_q = aud_bclk;
            ws_q   = aud_lrclk;
        end
    end

    //----------------------------------------------------------------------
    // Reset, run and end of test

    initial begin
        int waited;
        arst_n = 1'b0;
        key    = '1;
        mic_sd = 1'b0;
        for (int w = 0; w < n_window; w++)
            tone_seen[w] = 1'b0;
        $readmemh("tb/audio_input.mem", vectors);
        repeat (10) @(posedge CLK);
        assert (led == 4'b1110) else report_mismatch("reset led", 4'b1110, led);
        assert (aud_sdata == 1'b0) else report_mismatch("reset sdata", 0, aud_sdata);
        arst_n <= 1'b1;
        start_frame(0);
        waited = 0;
        while (!done && waited < limit) begin
            @(posedge CLK);
            waited = waited + 1;
        end
        if (done) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Timeout: the DAC stream did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

endmodule
